/* design/uart_pkg.sv */
package uart_pkg;

  // One data byte on the serial line
  typedef logic [7:0] uart_byte_t;

  // Bit time in clock cycles
  typedef logic [15:0] uart_div_t;

  // Register address and write data of the config port
  typedef logic [1:0] uart_addr_t;
  typedef logic [15:0] uart_wdata_t;

  // Shortest legal bit time, keeps the half-bit sample point above zero
  localparam uart_div_t div_min = 16'd4;

  // Frame register bits 1:0, code 3 is not legal and reads as none
  typedef enum logic [1:0] {
    parity_none = 2'd0,
    parity_even = 2'd1,
    parity_odd  = 2'd2
  } parity_t;

  // Register map
  localparam uart_addr_t reg_div_addr   = 2'd0;
  localparam uart_addr_t reg_frame_addr = 2'd1;

  // Transmitter FSM
  typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_parity, tx_stop} tx_state_t;

  // Receiver FSM
  typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_parity, rx_stop} rx_state_t;

endpackage

/* design/uart_cfg_if.sv */
`timescale 1ns/1ps

interface uart_cfg_if;

  // Bit time in clock cycles, never below 4
  uart_pkg::uart_div_t divisor;

  // Frame format
  uart_pkg::parity_t parity;
  logic two_stop;

  // One-cycle pulse on every accepted register write
  logic cfg_change;

  // Register block drives the bus
  modport source (output divisor, output parity, output two_stop, output cfg_change);

  // Serializers only read it
  modport sink (input divisor, input parity, input two_stop, input cfg_change);

endinterface

/* design/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs #(
  parameter uart_pkg::uart_div_t DIV_RESET = 16'd8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_we,
  input  uart_pkg::uart_addr_t   cfg_addr,
  input  uart_pkg::uart_wdata_t  cfg_wdata,
  uart_cfg_if.source             cfg
);

  // Reset divisor goes through the same floor as a written one
  localparam uart_pkg::uart_div_t div_init =
    (DIV_RESET < uart_pkg::div_min) ? uart_pkg::div_min : DIV_RESET;

  logic div_we;
  logic frame_we;
  uart_pkg::uart_div_t div_clamped;
  uart_pkg::parity_t parity_wr;

  // Address decode, other addresses are dropped
  assign div_we   = cfg_we && (cfg_addr == uart_pkg::reg_div_addr);
  assign frame_we = cfg_we && (cfg_addr == uart_pkg::reg_frame_addr);

  // A divisor of 2 still gets a half-bit sample point of 2 cycles
  assign div_clamped = (cfg_wdata < uart_pkg::div_min) ? uart_pkg::div_min : cfg_wdata;

  // Illegal parity code 3 maps to no parity
  always_comb begin
    case (cfg_wdata[1:0])
      2'd1:    parity_wr = uart_pkg::parity_even;
      2'd2:    parity_wr = uart_pkg::parity_odd;
      default: parity_wr = uart_pkg::parity_none;
    endcase
  end

  // New values and the change pulse show up together, one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg.divisor    <= div_init;
      cfg.parity     <= uart_pkg::parity_none;
      cfg.two_stop   <= 1'b0;
      cfg.cfg_change <= 1'b0;
    end else begin
      cfg.cfg_change <= div_we || frame_we;
      if (div_we) begin
        cfg.divisor <= div_clamped;
      end
      if (frame_we) begin
        cfg.parity   <= parity_wr;
        // Bit 2 selects two stop bits
        cfg.two_stop <= cfg_wdata[2];
      end
    end
  end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic                  clk,
  input  logic                  rst_n,
  uart_cfg_if.sink              cfg,
  input  logic                  tx_stb,
  input  uart_pkg::uart_byte_t  tx_data,
  output logic                  tx_busy,
  output logic                  txd
);

  uart_pkg::tx_state_t state_q;

  // Cycles spent in the current bit
  uart_pkg::uart_div_t cnt_q;
  logic bit_end;

  // Byte being sent, shifted right as bits go out
  uart_pkg::uart_byte_t shift_q;
  logic [2:0] bit_idx_q;

  // XOR of the data bits already on the line
  logic par_q;

  // Set while the second stop bit is on the line
  logic second_stop_q;

  // Last cycle of the current bit period
  assign bit_end = (cnt_q == cfg.divisor - uart_pkg::uart_div_t'(1));

  // Busy from the start bit up to the end of the last stop bit
  assign tx_busy = (state_q != uart_pkg::tx_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= uart_pkg::tx_idle;
      cnt_q   <= '0;
      txd     <= 1'b1;
    end else if (cfg.cfg_change) begin
      // New timing or format, drop the frame and park the line high
      state_q <= uart_pkg::tx_idle;
      cnt_q   <= '0;
      txd     <= 1'b1;
    end else begin
      // Bit period counter wraps at every bit edge
      if (state_q == uart_pkg::tx_idle || bit_end) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + uart_pkg::uart_div_t'(1);
      end

      case (state_q)
        uart_pkg::tx_idle: begin
          // Strobe only taken here, so a strobe while busy is lost
          if (tx_stb) begin
            state_q <= uart_pkg::tx_start;
            txd     <= 1'b0;
            shift_q <= tx_data;
            par_q   <= 1'b0;
          end
        end

        uart_pkg::tx_start: begin
          if (bit_end) begin
            state_q   <= uart_pkg::tx_data;
            txd       <= shift_q[0];
            bit_idx_q <= 3'd0;
          end
        end

        uart_pkg::tx_data: begin
          if (bit_end) begin
            par_q   <= par_q ^ shift_q[0];
            shift_q <= shift_q >> 1;
            if (bit_idx_q == 3'd7) begin
              if (cfg.parity == uart_pkg::parity_none) begin
                state_q       <= uart_pkg::tx_stop;
                txd           <= 1'b1;
                second_stop_q <= 1'b0;
              end else begin
                // Even parity is the plain XOR, odd its inverse
                state_q <= uart_pkg::tx_parity;
                txd     <= par_q ^ shift_q[0] ^ (cfg.parity == uart_pkg::parity_odd);
              end
            end else begin
              bit_idx_q <= bit_idx_q + 3'd1;
              txd       <= shift_q[1];
            end
          end
        end

        uart_pkg::tx_parity: begin
          if (bit_end) begin
            state_q       <= uart_pkg::tx_stop;
            txd           <= 1'b1;
            second_stop_q <= 1'b0;
          end
        end

        uart_pkg::tx_stop: begin
          if (bit_end) begin
            if (cfg.two_stop && !second_stop_q) begin
              second_stop_q <= 1'b1;
            end else begin
              state_q <= uart_pkg::tx_idle;
            end
          end
        end

        default: begin
          state_q <= uart_pkg::tx_idle;
          txd     <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic                  clk,
  input  logic                  rst_n,
  uart_cfg_if.sink              cfg,
  input  logic                  rxd,
  output logic                  rx_stb,
  output uart_pkg::uart_byte_t  rx_data,
  output logic                  rx_parity_err,
  output logic                  rx_frame_err
);

  uart_pkg::rx_state_t state_q;

  // Two-flop synchronizer plus one more stage for edge detection
  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;
  logic start_edge;

  // Sample point counter
  uart_pkg::uart_div_t cnt_q;
  uart_pkg::uart_div_t half_m1;
  uart_pkg::uart_div_t full_m1;
  logic sample;

  // Received data, filled from the top so bit 0 ends up in the LSB
  uart_pkg::uart_byte_t data_q;
  logic [2:0] bit_idx_q;

  // Parity of the data bits seen so far
  logic par_q;

  assign start_edge = rxd_prev && !rxd_sync;

  // Start bit is checked half a bit in, every later bit a full bit after that
  assign half_m1 = (cfg.divisor >> 1) - uart_pkg::uart_div_t'(1);
  assign full_m1 = cfg.divisor - uart_pkg::uart_div_t'(1);
  assign sample  = (state_q == uart_pkg::rx_start) ? (cnt_q == half_m1) : (cnt_q == full_m1);

  // Data holds after the stop sample until the next frame shifts in
  assign rx_data = data_q;

  // Line idles high, so the chain resets to 1 and no false start follows reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= uart_pkg::rx_idle;
      cnt_q   <= '0;
      rx_stb  <= 1'b0;
    end else if (cfg.cfg_change) begin
      // Abort so no frame is sampled with mixed bit times
      state_q <= uart_pkg::rx_idle;
      cnt_q   <= '0;
      rx_stb  <= 1'b0;
    end else begin
      rx_stb <= 1'b0;

      if (state_q == uart_pkg::rx_idle || sample) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + uart_pkg::uart_div_t'(1);
      end

      case (state_q)
        uart_pkg::rx_idle: begin
          // Needs a high to low edge, a line stuck low after a bad frame waits
          if (start_edge) begin
            state_q <= uart_pkg::rx_start;
          end
        end

        uart_pkg::rx_start: begin
          if (sample) begin
            if (rxd_sync) begin
              // Glitch, line went back high before mid-bit
              state_q <= uart_pkg::rx_idle;
            end else begin
              state_q       <= uart_pkg::rx_data;
              bit_idx_q     <= 3'd0;
              par_q         <= 1'b0;
              rx_parity_err <= 1'b0;
            end
          end
        end

        uart_pkg::rx_data: begin
          if (sample) begin
            data_q <= {rxd_sync, data_q[7:1]};
            par_q  <= par_q ^ rxd_sync;
            if (bit_idx_q == 3'd7) begin
              if (cfg.parity == uart_pkg::parity_none) begin
                state_q <= uart_pkg::rx_stop;
              end else begin
                state_q <= uart_pkg::rx_parity;
              end
            end else begin
              bit_idx_q <= bit_idx_q + 3'd1;
            end
          end
        end

        uart_pkg::rx_parity: begin
          if (sample) begin
            // Mismatch against the expected even or odd bit
            rx_parity_err <= rxd_sync ^ par_q ^ (cfg.parity == uart_pkg::parity_odd);
            state_q       <= uart_pkg::rx_stop;
          end
        end

        uart_pkg::rx_stop: begin
          // Only the first stop bit is checked, a second one passes as idle
          if (sample) begin
            rx_stb       <= 1'b1;
            rx_frame_err <= !rxd_sync;
            state_q      <= uart_pkg::rx_idle;
          end
        end

        default: begin
          state_q <= uart_pkg::rx_idle;
        end
      endcase
    end
  end

endmodule

/* design/uart_top.sv */
`timescale 1ns/1ps

module uart_top #(
  parameter uart_pkg::uart_div_t DIV_RESET = 16'd8
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Config register write port
  input  logic                   cfg_we,
  input  uart_pkg::uart_addr_t   cfg_addr,
  input  uart_pkg::uart_wdata_t  cfg_wdata,

  // Transmit side
  input  logic                   tx_stb,
  input  uart_pkg::uart_byte_t   tx_data,
  output logic                   tx_busy,
  output logic                   txd,

  // Receive side
  input  logic                   rxd,
  output logic                   rx_stb,
  output uart_pkg::uart_byte_t   rx_data,
  output logic                   rx_parity_err,
  output logic                   rx_frame_err
);

  // Shared frame configuration
  uart_cfg_if cfg_bus ();

  uart_regs #(
    .DIV_RESET (DIV_RESET)
  ) regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg_bus.source)
  );

  uart_tx tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg_bus.sink),
    .tx_stb  (tx_stb),
    .tx_data (tx_data),
    .tx_busy (tx_busy),
    .txd     (txd)
  );

  uart_rx rx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg           (cfg_bus.sink),
    .rxd           (rxd),
    .rx_stb        (rx_stb),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

/* bench/uart_term.sv */
`timescale 1ns/1ps

module uart_term (
  input  logic clk,
  input  logic line_in,
  output logic line_out
);

  // Frame format, kept in step with the DUT registers by the testbench
  int bit_cycles = 8;
  uart_pkg::parity_t par_mode = uart_pkg::parity_none;
  logic two_stop = 1'b0;

  // Frames decoded from the DUT transmit line
  uart_pkg::uart_byte_t seen_data[$];
  logic seen_par[$];
  logic seen_stop[$];

  // Idle line is high
  initial begin
    line_out = 1'b1;
  end

  task automatic set_cfg(input int cycles, input uart_pkg::parity_t mode, input logic stop2);
    bit_cycles = cycles;
    par_mode   = mode;
    two_stop   = stop2;
  endtask

  // One bit on the line for a full bit time
  task automatic drive_bit(input logic v);
    @(posedge clk);
    line_out <= v;
    repeat (bit_cycles - 1) @(posedge clk);
  endtask

  // Frame towards the DUT, optionally with a wrong parity bit or a low stop bit
  task automatic send(input uart_pkg::uart_byte_t b, input logic flip_par,
                      input logic low_stop);
    logic par;
    int i;
    // Even parity is the XOR of the data, odd parity its inverse
    par = (^b) ^ (par_mode == uart_pkg::parity_odd) ^ flip_par;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    if (par_mode != uart_pkg::parity_none) begin
      drive_bit(par);
    end
    drive_bit(!low_stop);
    // Second stop bit, or the line brought back high after a bad stop bit
    if (two_stop || low_stop) begin
      drive_bit(1'b1);
    end
  endtask

  function automatic int frames_seen();
    return seen_data.size();
  endfunction

  task automatic pop_frame(output uart_pkg::uart_byte_t b, output logic par,
                           output logic stop_ok);
    b       = seen_data.pop_front();
    par     = seen_par.pop_front();
    stop_ok = seen_stop.pop_front();
  endtask

  // Decoder for the DUT transmit line, samples at mid-bit on the falling edge
  always begin : monitor
    uart_pkg::uart_byte_t b;
    logic par;
    logic stop_ok;
    int cycles;
    int i;
    @(negedge clk);
    if (line_in === 1'b0) begin
      cycles = bit_cycles;
      repeat (cycles / 2) @(negedge clk);
      // A start bit that is gone by mid-bit is ignored
      if (line_in === 1'b0) begin
        for (i = 0; i < 8; i++) begin
          repeat (cycles) @(negedge clk);
          b[i] = line_in;
        end
        par = 1'b0;
        if (par_mode != uart_pkg::parity_none) begin
          repeat (cycles) @(negedge clk);
          par = line_in;
        end
        repeat (cycles) @(negedge clk);
        stop_ok = (line_in === 1'b1);
        if (two_stop) begin
          repeat (cycles) @(negedge clk);
          stop_ok = stop_ok && (line_in === 1'b1);
        end
        seen_data.push_back(b);
        seen_par.push_back(par);
        seen_stop.push_back(stop_ok);
      end
    end
  end

endmodule

/* bench/uart_props.sv */
`timescale 1ns/1ps

module uart_props (
  input logic clk,
  input logic rst_n,
  input logic tx_busy,
  input logic txd,
  input logic rx_stb
);

  // Line parks high whenever no frame is being sent
  txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> txd)
    else $error("txd low while tx_busy is low");

  // Receive strobe is a single-cycle pulse
  rx_stb_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_stb |=> !rx_stb)
    else $error("rx_stb held high for two cycles");

  // Transmitter comes out of reset idle
  busy_after_reset: assert property (@(posedge clk) !rst_n |=> !tx_busy)
    else $error("tx_busy high in the cycle after reset");

endmodule

bind uart_top uart_props props_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .tx_busy (tx_busy),
  .txd     (txd),
  .rx_stb  (rx_stb)
);

/* bench/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;

  localparam uart_pkg::uart_div_t div_reset = 16'd8;

  logic clk;
  logic rst_n;
  logic cfg_we;
  uart_pkg::uart_addr_t cfg_addr;
  uart_pkg::uart_wdata_t cfg_wdata;
  logic tx_stb;
  uart_pkg::uart_byte_t tx_data;
  logic tx_busy;
  logic txd;
  logic rxd;
  logic rx_stb;
  uart_pkg::uart_byte_t rx_data;
  logic rx_parity_err;
  logic rx_frame_err;

  // Reference copy of the frame format
  int cur_div;
  uart_pkg::parity_t cur_par;
  logic cur_two_stop;

  logic [31:0] rng;
  int errors;
  int timeouts;

  // Receive strobes captured at the falling edge
  uart_pkg::uart_byte_t got_data[$];
  logic got_perr[$];
  logic got_ferr[$];

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  uart_top #(
    .DIV_RESET (div_reset)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .tx_stb        (tx_stb),
    .tx_data       (tx_data),
    .tx_busy       (tx_busy),
    .txd           (txd),
    .rxd           (rxd),
    .rx_stb        (rx_stb),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  // Far end of the serial line, looped to the DUT pins
  uart_term term_i (
    .clk      (clk),
    .line_in  (txd),
    .line_out (rxd)
  );

  always @(negedge clk) begin
    if (rst_n === 1'b1 && rx_stb === 1'b1) begin
      got_data.push_back(rx_data);
      got_perr.push_back(rx_parity_err);
      got_ferr.push_back(rx_frame_err);
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic uart_pkg::parity_t pick_parity(input logic [31:0] r);
    case (r % 32'd3)
      32'd0:   return uart_pkg::parity_none;
      32'd1:   return uart_pkg::parity_even;
      default: return uart_pkg::parity_odd;
    endcase
  endfunction

  // Start, 8 data, stop, plus parity and second stop when enabled
  function automatic int frame_bits();
    return 10 + ((cur_par != uart_pkg::parity_none) ? 1 : 0) + (cur_two_stop ? 1 : 0);
  endfunction

  // 20 frame times
  function automatic int wait_limit();
    return 20 * cur_div * frame_bits();
  endfunction

  task automatic write_reg(input uart_pkg::uart_addr_t addr, input int data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= uart_pkg::uart_wdata_t'(data);
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic configure(input int div, input uart_pkg::parity_t par, input logic stop2);
    write_reg(uart_pkg::reg_div_addr, div);
    write_reg(uart_pkg::reg_frame_addr, (stop2 ? 4 : 0) + int'(par));
    // Divisors below 4 act as 4
    cur_div      = (div < 4) ? 4 : div;
    cur_par      = par;
    cur_two_stop = stop2;
    term_i.set_cfg(cur_div, par, stop2);
    @(posedge clk);
  endtask

  // Strobe one byte out, check busy time, start bit length and the decoded frame
  task automatic check_tx(input uart_pkg::uart_byte_t b);
    int busy;
    int start_len;
    int n;
    logic seen_high;
    uart_pkg::uart_byte_t got;
    logic par;
    logic stop_ok;
    logic exp_par;
    busy      = 0;
    start_len = 0;
    n         = 0;
    seen_high = 1'b0;
    @(posedge clk);
    tx_stb  <= 1'b1;
    tx_data <= b;
    @(posedge clk);
    tx_stb <= 1'b0;
    do begin
      @(negedge clk);
      n++;
      if (tx_busy) begin
        busy++;
        if (txd) begin
          seen_high = 1'b1;
        end else if (!seen_high) begin
          start_len++;
        end
      end
    end while ((tx_busy || busy == 0) && n < wait_limit());
    if (tx_busy || busy == 0) begin
      timeouts++;
      $display("Timeout: tx_busy did not finish a frame after a transmit strobe");
      return;
    end
    assert (busy == cur_div * frame_bits()) else begin
      errors++;
      $display("Error at %0t ns: tx_busy lasted %0d cycles, expected %0d",
               $time, busy, cur_div * frame_bits());
    end
    // Start bit is measurable only when data bit 0 ends it
    if (b[0]) begin
      assert (start_len == cur_div) else begin
        errors++;
        $display("Error at %0t ns: bit time on txd %0d cycles, expected %0d",
                 $time, start_len, cur_div);
      end
    end
    n = 0;
    while (term_i.frames_seen() == 0 && n < wait_limit()) begin
      @(negedge clk);
      n++;
    end
    if (term_i.frames_seen() == 0) begin
      timeouts++;
      $display("Timeout: the terminal decoded no frame from txd");
      return;
    end
    term_i.pop_frame(got, par, stop_ok);
    assert (got == b && stop_ok) else begin
      errors++;
      $display("Error at %0t ns: txd frame %h stop %b, expected %h stop 1",
               $time, got, stop_ok, b);
    end
    if (cur_par != uart_pkg::parity_none) begin
      exp_par = (^b) ^ (cur_par == uart_pkg::parity_odd);
      assert (par == exp_par) else begin
        errors++;
        $display("Error at %0t ns: parity bit %b for %h, expected %b", $time, par, b, exp_par);
      end
    end
  endtask

  // Terminal sends one frame, the DUT must strobe it out with the right flags
  task automatic check_rx(input uart_pkg::uart_byte_t b, input logic flip_par,
                          input logic low_stop);
    int n;
    uart_pkg::uart_byte_t got;
    logic perr;
    logic ferr;
    logic exp_perr;
    term_i.send(b, flip_par, low_stop);
    n = 0;
    while (got_data.size() == 0 && n < wait_limit()) begin
      @(negedge clk);
      n++;
    end
    if (got_data.size() == 0) begin
      timeouts++;
      $display("Timeout: the DUT gave no receive strobe for a frame on rxd");
      return;
    end
    got  = got_data.pop_front();
    perr = got_perr.pop_front();
    ferr = got_ferr.pop_front();
    // A flipped parity bit counts only when a parity bit is sent
    exp_perr = flip_par && (cur_par != uart_pkg::parity_none);
    assert (got == b && perr == exp_perr && ferr == low_stop) else begin
      errors++;
      $display("Error at %0t ns: rx %h perr %b ferr %b, expected %h perr %b ferr %b",
               $time, got, perr, ferr, b, exp_perr, low_stop);
    end
  endtask

  initial begin
    logic [31:0] r;
    int round;
    rng          = 32'd89647;
    errors       = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    tx_stb       = 1'b0;
    tx_data      = '0;
    cur_div      = int'(div_reset);
    cur_par      = uart_pkg::parity_none;
    cur_two_stop = 1'b0;
    term_i.set_cfg(cur_div, cur_par, cur_two_stop);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (txd === 1'b1 && tx_busy === 1'b0 && rx_stb === 1'b0) else begin
      errors++;
      $display("Error at %0t ns: after reset txd %b tx_busy %b rx_stb %b",
               $time, txd, tx_busy, rx_stb);
    end

    // Reset format, both directions
    repeat (8) begin
      r = next_rand();
      check_tx(r[7:0]);
    end
    repeat (4) begin
      r = next_rand();
      check_rx(r[7:0], 1'b0, 1'b0);
    end

    // Random divisor, parity and stop bits
    for (round = 0; round < 6; round++) begin
      r = next_rand();
      configure(4 + int'(r[3:0]), pick_parity(r >> 8), r[12]);
      repeat (4) begin
        r = next_rand();
        check_tx(r[7:0]);
      end
      repeat (4) begin
        r = next_rand();
        check_rx(r[7:0], 1'b0, 1'b0);
      end
    end

    // Flipped parity bits, then a clean frame
    r = next_rand();
    configure(6 + int'(r[2:0]), r[4] ? uart_pkg::parity_even : uart_pkg::parity_odd, r[5]);
    repeat (4) begin
      r = next_rand();
      check_rx(r[7:0], 1'b1, 1'b0);
    end
    r = next_rand();
    check_rx(r[7:0], 1'b0, 1'b0);

    // Low stop bit, one idle frame, then a good frame
    r = next_rand();
    check_rx(r[7:0], 1'b0, 1'b1);
    repeat (cur_div * frame_bits()) @(posedge clk);
    r = next_rand();
    check_rx(r[7:0], 1'b0, 1'b0);

    // Divisor of 2 runs at 4, bit 0 set so the start bit can be timed
    configure(2, uart_pkg::parity_none, 1'b0);
    // Unmapped address, the value would change divisor and format if it were decoded
    write_reg(2'd2, 6);
    repeat (4) begin
      r = next_rand();
      check_tx(r[7:0] | 8'h01);
    end
    repeat (4) begin
      r = next_rand();
      check_rx(r[7:0], 1'b0, 1'b0);
    end

    // Another bit time after that
    r = next_rand();
    configure(5 + int'(r[3:0]), pick_parity(r >> 8), r[12]);
    repeat (4) begin
      r = next_rand();
      check_tx(r[7:0] | 8'h01);
    end
    repeat (4) begin
      r = next_rand();
      check_rx(r[7:0], 1'b0, 1'b0);
    end

    $display("Checks done: %0d error(s), %0d timeout(s)", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/uart_pkg.sv
design/uart_cfg_if.sv
design/uart_regs.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
bench/uart_term.sv
bench/uart_props.sv
bench/uart_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := uart_tb
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
